//--- dv/rx_cases.txt
# name bit8 par_en odd data flip_par low_stop glitch burst clear exp_data exp_perr exp_ferr exp_ovf
# data and exp_data in hex; burst is the number of frames sent before the first read
b8_a5         1 0 0 a5 0 0 0 1 0 a5 0 0 0
b8_3c         1 0 0 3c 0 0 0 1 0 3c 0 0 0
b8_ff         1 0 0 ff 0 0 0 1 0 ff 0 0 0
b8_00         1 0 0 00 0 0 0 1 0 00 0 0 0
b7_even_55    0 1 0 55 0 0 0 1 0 55 0 0 0
b7_even_ca    0 1 0 ca 0 0 0 1 0 4a 0 0 0
b7_odd_2d     0 1 1 2d 0 0 0 1 0 2d 0 0 0
b7_odd_f1     0 1 1 f1 0 0 0 1 0 71 0 0 0
b7_plain_e6   0 0 0 e6 0 0 0 1 0 66 0 0 0
b8_even_96    1 1 0 96 0 0 0 1 0 96 0 0 0
b8_odd_69     1 1 1 69 0 0 0 1 0 69 0 0 0
par_flip      1 1 0 5a 1 0 0 1 0 5a 1 0 0
par_held      1 0 0 11 0 0 0 1 0 11 0 0 0
par_clear     1 0 0 22 0 0 0 1 1 22 0 0 0
b7_odd_flip   0 1 1 3e 1 0 0 1 0 3e 1 0 0
b7_flip_clear 0 1 1 41 0 0 0 1 1 41 0 0 0
stop_low      1 0 0 c3 0 1 0 1 0 c3 0 1 0
stop_held     1 1 1 7e 0 0 0 1 0 7e 0 0 0
stop_clear    1 0 0 3a 0 0 0 1 1 3a 0 0 0
both_err      1 1 0 b4 1 1 0 1 0 b4 1 1 0
both_clear    0 1 0 19 0 0 0 1 1 19 0 0 0
glitch_08     1 0 0 08 0 0 1 1 0 08 0 0 0
glitch_f7     1 1 1 f7 0 0 1 1 0 f7 0 0 0
glitch_b7     0 0 0 77 0 0 1 1 0 77 0 0 0
burst_ovf     1 0 0 e1 0 0 0 5 0 e1 0 0 1
ovf_held      1 0 0 5c 0 0 0 1 0 5c 0 0 1
ovf_clear     1 0 0 d2 0 0 0 1 1 d2 0 0 0

//--- all.f
hdl/uart_rx_pkg.sv
hdl/rx_deserializer.sv
hdl/rx_char_buffer.sv
hdl/rx_host_port.sv
hdl/uart_rx_top.sv
dv/uart_rx_tb.sv

//--- Makefile
# Verilator build and run for the uart receiver testbench

VERILATOR ?= verilator
TOP       ?= uart_rx_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Simulation PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/uart_rx_tb.sv
/* uart receiver testbench */
`default_nettype none
`timescale 1ns/1ns

module uart_rx_tb;
  import uart_rx_pkg::*;

  localparam int FIFO_DEPTH   = 4;
  localparam int MAX_CASES    = 64;
  localparam int CLKS_PER_BIT = TICKS_PER_BIT * 2;  // baud tick on every other clock
  localparam int WAIT_CLKS    = 11 * CLKS_PER_BIT;  // longest frame

  typedef struct packed {
    frame_cfg_t cfg;
    logic [7:0] data;
    logic       flip_par;
    logic       low_stop;
    logic       glitch;
    logic [3:0] burst;     // frames sent before the read
    logic       clear;
    rx_char_t   exp_char;
    logic       exp_ovf;
  } case_t;

  logic       clk;
  logic       aresetn;
  logic       baud_tick;
  logic       rx;
  frame_cfg_t cfg;
  logic       read_rx_byte;
  logic       clear_errors;
  rx_char_t   rx_char;
  logic       receive_full;
  logic       overflow;
  logic       parity_err;
  logic       framing_err;

  case_t           tcases [MAX_CASES];
  logic [8*24-1:0] names [MAX_CASES];
  int              n_cases;
  integer          seed;
  int              watchdog_ns;
  logic            sticky_perr;  // model of the sticky host flags
  logic            sticky_ferr;
  logic [7:0]      burst_data [$];

  uart_rx_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .clk          (clk),
    .aresetn      (aresetn),
    .baud_tick    (baud_tick),
    .rx           (rx),
    .cfg          (cfg),
    .read_rx_byte (read_rx_byte),
    .clear_errors (clear_errors),
    .rx_char      (rx_char),
    .receive_full (receive_full),
    .overflow     (overflow),
    .parity_err   (parity_err),
    .framing_err  (framing_err)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    #10;
    baud_tick = ~baud_tick;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic send_bit(input logic value, input logic glitch);
    rx = value;
    repeat (CLKS_PER_BIT / 2 - 2) next_cycle();
    if (glitch)
      rx = ~value;  // two clocks hold exactly one baud tick
    repeat (2) next_cycle();
    rx = value;
    repeat (CLKS_PER_BIT / 2) next_cycle();
  endtask

  task automatic send_frame(input frame_cfg_t fc, input logic [7:0] data,
                            input logic flip_par, input logic low_stop,
                            input logic glitch);
    int   nbits;
    logic par;
    nbits = fc.bit8 ? 8 : 7;
    par   = fc.odd_n_even;  // odd parity starts from 1
    send_bit(1'b0, 1'b0);
    for (int i = 0; i < nbits; i++)
    begin
      par = par ^ data[i];
      send_bit(data[i], glitch && (i == 3));
    end
    if (fc.parity_en)
      send_bit(par ^ flip_par, 1'b0);
    send_bit(~low_stop, 1'b0);
    rx = 1'b1;
    repeat (2 * CLKS_PER_BIT) next_cycle();  // idle gap re-arms the receiver
  endtask

  task automatic wait_ready(input logic [8*24-1:0] name);
    int waited;
    waited = 0;
    while (!receive_full)
    begin
      if (waited == WAIT_CLKS)
      begin
        $display("%0s: no character reached the receive buffer in time", name);
        $display("Simulation FAILED");
        $fatal(1, "receive timeout");
      end
      else
      begin
        next_cycle();
        waited++;
      end
    end
  endtask

  task automatic read_char();
    read_rx_byte = 1'b1;
    next_cycle();
    read_rx_byte = 1'b0;
  endtask

  task automatic pulse_clear();
    clear_errors = 1'b1;
    next_cycle();
    clear_errors = 1'b0;
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_char(input logic [8*24-1:0] name, input rx_char_t want,
                            input rx_char_t got);
    if (got !== want)
    begin
      $display("FAIL %0s: expected data=%02h perr=%b ferr=%b, actual data=%02h perr=%b ferr=%b",
               name, want.data, want.parity_err, want.framing_err,
               got.data, got.parity_err, got.framing_err);
      $display("Simulation FAILED");
      $fatal(1, "character mismatch");
    end
  endtask

  task automatic check_flag(input logic [8*24-1:0] name, input string what,
                            input logic want, input logic got);
    if (got !== want)
    begin
      $display("FAIL %0s: %0s expected %b, actual %b", name, what, want, got);
      $display("Simulation FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  // ------------------------------
  // case file
  // ------------------------------
  task automatic load_cases();
    int               fd;
    int               n;
    logic [8*128-1:0] line;
    logic [8*24-1:0]  tok;
    int               b8, pe, od, dat, fl, ls, gl, bu, cl;
    int               ed, ep, ef, eo;
    n_cases = 0;
    fd = $fopen("dv/rx_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open dv/rx_cases.txt");
      $display("Simulation FAILED");
      $fatal(1, "missing case file");
    end
    else
    begin
      while (!$feof(fd) && n_cases < MAX_CASES)
      begin
        line = '0;
        tok  = '0;
        n = $fgets(line, fd);
        if ($sscanf(line, "%s", tok) == 1 && tok != (8*24)'("#"))
        begin
          n = $sscanf(line, "%s %d %d %d %h %d %d %d %d %d %h %d %d %d", tok,
                      b8, pe, od, dat, fl, ls, gl, bu, cl, ed, ep, ef, eo);
          if (n != 14)
          begin
            $display("malformed line in the case file: %0s", line);
            $display("Simulation FAILED");
            $fatal(1, "bad case line");
          end
          else
          begin
            names[n_cases] = tok;
            tcases[n_cases].cfg      = '{bit8: b8[0], parity_en: pe[0], odd_n_even: od[0]};
            tcases[n_cases].data     = dat[7:0];
            tcases[n_cases].flip_par = fl[0];
            tcases[n_cases].low_stop = ls[0];
            tcases[n_cases].glitch   = gl[0];
            tcases[n_cases].burst    = bu[3:0];
            tcases[n_cases].clear    = cl[0];
            tcases[n_cases].exp_char = '{data: ed[7:0], parity_err: ep[0], framing_err: ef[0]};
            tcases[n_cases].exp_ovf  = eo[0];
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input int c);
    case_t           tc;
    logic [8*24-1:0] name;
    logic [7:0]      extra;
    rx_char_t        want;
    int              kept;
    tc   = tcases[c];
    name = names[c];
    cfg  = tc.cfg;
    burst_data.delete();
    send_frame(tc.cfg, tc.data, tc.flip_par, tc.low_stop, tc.glitch);
    for (int i = 1; i < int'(tc.burst); i++)
    begin
      extra = 8'($random(seed));
      if (!tc.cfg.bit8)
        extra[7] = 1'b0;
      burst_data.push_back(extra);
      send_frame(tc.cfg, extra, 1'b0, 1'b0, 1'b0);
    end
    wait_ready(name);
    if (tc.clear)
    begin
      pulse_clear();
      sticky_perr = 1'b0;
      sticky_ferr = 1'b0;
    end
    read_char();
    check_char(name, tc.exp_char, rx_char);
    sticky_perr = sticky_perr | tc.exp_char.parity_err;
    sticky_ferr = sticky_ferr | tc.exp_char.framing_err;
    // only FIFO_DEPTH frames survive a burst, oldest first
    kept = (int'(tc.burst) < FIFO_DEPTH) ? int'(tc.burst) : FIFO_DEPTH;
    for (int i = 1; i < kept; i++)
    begin
      want = '{data: burst_data[i-1], parity_err: 1'b0, framing_err: 1'b0};
      wait_ready(name);
      read_char();
      check_char(name, want, rx_char);
    end
    check_flag(name, "receive_full", 1'b0, receive_full);
    check_flag(name, "parity_err", sticky_perr, parity_err);
    check_flag(name, "framing_err", sticky_ferr, framing_err);
    check_flag(name, "overflow", tc.exp_ovf, overflow);
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial
  begin
    int frames;
    clk          = 1'b0;
    aresetn      = 1'b0;
    baud_tick    = 1'b0;
    rx           = 1'b1;  // idle line
    cfg          = '0;
    read_rx_byte = 1'b0;
    clear_errors = 1'b0;
    seed         = 32'h7f5fa1de;
    sticky_perr  = 1'b0;
    sticky_ferr  = 1'b0;
    watchdog_ns  = 0;
    load_cases();
    frames = 0;
    for (int c = 0; c < n_cases; c++)
      frames = frames + int'(tcases[c].burst);
    watchdog_ns = frames * 11 * TICKS_PER_BIT * 2 * 100;
    watchdog_ns = watchdog_ns + watchdog_ns / 2 + 20000;  // gaps, reads and reset
    repeat (10) next_cycle();
    aresetn = 1'b1;
    repeat (4) next_cycle();
    check_char("after_reset", '0, rx_char);
    check_flag("after_reset", "receive_full", 1'b0, receive_full);
    check_flag("after_reset", "overflow", 1'b0, overflow);
    for (int c = 0; c < n_cases; c++)
      run_case(c);
    $display("Simulation PASSED");
    $finish;
  end

  initial
  begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("watchdog expired before all cases finished");
    $display("Simulation FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

//--- hdl/uart_rx_top.sv
/* uart receiver top */
`default_nettype none
`timescale 1ns/1ns

module uart_rx_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                    clk,
  input  wire logic                    aresetn,
  input  wire logic                    baud_tick,
  input  wire logic                    rx,
  input  wire uart_rx_pkg::frame_cfg_t cfg,           // hold stable between frames
  input  wire logic                    read_rx_byte,
  input  wire logic                    clear_errors,
  output uart_rx_pkg::rx_char_t        rx_char,
  output logic                         receive_full,  // buffer holds a character
  output logic                         overflow,
  output logic                         parity_err,
  output logic                         framing_err
);
  import uart_rx_pkg::*;

  logic     char_wr;
  rx_char_t char_in;
  rx_char_t head;
  logic     ovf_pulse;
  logic     pop;

  rx_deserializer u_deser (
    .clk       (clk),
    .aresetn   (aresetn),
    .baud_tick (baud_tick),
    .rx        (rx),
    .cfg       (cfg),
    .char_wr   (char_wr),
    .char_in   (char_in)
  );

  rx_char_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_buf (
    .clk       (clk),
    .aresetn   (aresetn),
    .char_wr   (char_wr),
    .char_in   (char_in),
    .pop       (pop),
    .not_empty (receive_full),
    .head      (head),
    .ovf_pulse (ovf_pulse)
  );

  rx_host_port u_host (
    .clk          (clk),
    .aresetn      (aresetn),
    .read_rx_byte (read_rx_byte),
    .clear_errors (clear_errors),
    .not_empty    (receive_full),
    .head         (head),
    .ovf_pulse    (ovf_pulse),
    .pop          (pop),
    .rx_char      (rx_char),
    .overflow     (overflow),
    .parity_err   (parity_err),
    .framing_err  (framing_err)
  );

endmodule

`default_nettype wire

//--- hdl/rx_host_port.sv
/* host read port */
`default_nettype none
`timescale 1ns/1ns

module rx_host_port (
  input  wire logic                  clk,
  input  wire logic                  aresetn,
  input  wire logic                  read_rx_byte,
  input  wire logic                  clear_errors,
  input  wire logic                  not_empty,
  input  wire uart_rx_pkg::rx_char_t head,
  input  wire logic                  ovf_pulse,
  output logic                       pop,
  output uart_rx_pkg::rx_char_t      rx_char,
  output logic                       overflow,
  output logic                       parity_err,
  output logic                       framing_err
);

  // a read with nothing buffered is ignored
  assign pop = read_rx_byte && not_empty;

  // ------------------------------
  // read register
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_char <= '0;
    end
    else if (pop)
    begin
      rx_char <= head;
    end
  end

  // ------------------------------
  // sticky error flags
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      overflow    <= 1'b0;
      parity_err  <= 1'b0;
      framing_err <= 1'b0;
    end
    else
    begin
      // set beats clear
      if (ovf_pulse)
        overflow <= 1'b1;
      else if (clear_errors)
        overflow <= 1'b0;

      if (pop && head.parity_err)
        parity_err <= 1'b1;
      else if (clear_errors)
        parity_err <= 1'b0;

      if (pop && head.framing_err)
        framing_err <= 1'b1;
      else if (clear_errors)
        framing_err <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rx_char_buffer.sv
/* received character FIFO */
`default_nettype none
`timescale 1ns/1ns

module rx_char_buffer #(
  parameter int FIFO_DEPTH = 4  // power of two, 2 or more
) (
  input  wire logic                  clk,
  input  wire logic                  aresetn,
  input  wire logic                  char_wr,
  input  wire uart_rx_pkg::rx_char_t char_in,
  input  wire logic                  pop,
  output logic                       not_empty,
  output uart_rx_pkg::rx_char_t      head,
  output logic                       ovf_pulse
);
  import uart_rx_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  rx_char_t      mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;    // one bit wider than the pointers
  logic          full;
  logic          do_wr;

  assign full      = (count == (AW + 1)'(FIFO_DEPTH));
  assign do_wr     = char_wr && !full;  // full drops the character
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  // ------------------------------
  // storage
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= char_in;
    end
  end

  // ------------------------------
  // pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      ovf_pulse <= 1'b0;
    end
    else
    begin
      ovf_pulse <= char_wr && full;
      if (do_wr)
      begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at the power of two
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/rx_deserializer.sv
/* uart frame deserializer */
`default_nettype none
`timescale 1ns/1ns

module rx_deserializer (
  input  wire logic                    clk,
  input  wire logic                    aresetn,
  input  wire logic                    baud_tick,  // 16x oversampling strobe
  input  wire logic                    rx,
  input  wire uart_rx_pkg::frame_cfg_t cfg,
  output logic                         char_wr,
  output uart_rx_pkg::rx_char_t        char_in
);
  import uart_rx_pkg::*;

  localparam int TCNT_W = $clog2(TICKS_PER_BIT);
  localparam int BCNT_W = $clog2(DATA_W);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_t;

  logic [2:0]        samples;      // last three line samples
  logic              rx_filtered;
  rx_state_t         state;
  logic [TCNT_W-1:0] tick_cnt;
  logic [BCNT_W-1:0] bit_cnt;      // index of the data bit being taken
  logic [DATA_W-1:0] shift;
  logic              par_acc;      // running xor of data bits
  logic              par_err_q;
  logic              armed;        // line seen high since last frame
  logic              start_found;
  logic              bit_end;
  logic              sample;
  logic              last_data;
  logic [DATA_W-1:0] data_aligned;

  // ------------------------------
  // majority filter
  // ------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111;  // idle line level
    end
    else if (baud_tick)
    begin
      samples <= {rx, samples[2:1]};
    end
  end

  // two out of three wins
  assign rx_filtered = (samples[0] & samples[1]) |
                       (samples[1] & samples[2]) |
                       (samples[0] & samples[2]);

  // ------------------------------
  // bit timing
  // ------------------------------
  assign start_found = (state == ST_IDLE) && !rx_filtered && armed &&
                       (tick_cnt == TCNT_W'(START_MID_TICKS - 1));
  assign bit_end     = (state != ST_IDLE) &&
                       (tick_cnt == TCNT_W'(TICKS_PER_BIT - 1));
  assign sample      = baud_tick && bit_end;  // middle of a bit

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      tick_cnt <= '0;
    end
    else if (baud_tick)
    begin
      if (state == ST_IDLE)
      begin
        // count consecutive low ticks only
        if (rx_filtered || !armed || start_found)
        begin
          tick_cnt <= '0;
        end
        else
        begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end
      else if (bit_end)
      begin
        tick_cnt <= '0;
      end
      else
      begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // frame state machine
  // ------------------------------
  assign last_data = (bit_cnt == (cfg.bit8 ? BCNT_W'(DATA_W - 1) : BCNT_W'(DATA_W - 2)));

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state     <= ST_IDLE;
      bit_cnt   <= '0;
      par_acc   <= 1'b0;
      par_err_q <= 1'b0;
      armed     <= 1'b0;
      char_wr   <= 1'b0;
    end
    else
    begin
      char_wr <= 1'b0;
      if (baud_tick)
      begin
        case (state)
          ST_IDLE:
          begin
            if (rx_filtered)
            begin
              armed <= 1'b1;
            end
            if (start_found)
            begin
              state     <= ST_DATA;
              bit_cnt   <= '0;
              par_acc   <= 1'b0;
              par_err_q <= 1'b0;  // stays 0 without parity
            end
          end
          ST_DATA:
          begin
            if (bit_end)
            begin
              par_acc <= par_acc ^ rx_filtered;
              if (last_data)
              begin
                state <= cfg.parity_en ? ST_PARITY : ST_STOP;
              end
              else
              begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
          ST_PARITY:
          begin
            if (bit_end)
            begin
              // expected bit is par_acc, inverted for odd parity
              par_err_q <= rx_filtered ^ par_acc ^ cfg.odd_n_even;
              state     <= ST_STOP;
            end
          end
          ST_STOP:
          begin
            if (bit_end)
            begin
              char_wr <= 1'b1;
              armed   <= 1'b0;  // a low stop must go high before a new start
              state   <= ST_IDLE;
            end
          end
          default:
          begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  // ------------------------------
  // shift register and output word
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (sample && (state == ST_DATA))
    begin
      shift <= {rx_filtered, shift[DATA_W-1:1]};  // lsb first
    end
  end

  // 7-bit frames end up one place high
  assign data_aligned = cfg.bit8 ? shift : {1'b0, shift[DATA_W-1:1]};

  always_ff @(posedge clk)
  begin
    if (sample && (state == ST_STOP))
    begin
      char_in.data        <= data_aligned;
      char_in.parity_err  <= par_err_q;
      char_in.framing_err <= ~rx_filtered;  // stop bit must be high
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_rx_pkg.sv
/* uart receiver types and constants */
`default_nettype none

package uart_rx_pkg;

  // ------------------------------
  // frame format
  // ------------------------------
  typedef struct packed {
    logic bit8;        // 1: 8 data bits, 0: 7 data bits
    logic parity_en;   // parity bit follows the data
    logic odd_n_even;  // 1: odd parity, 0: even
  } frame_cfg_t;

  localparam int DATA_W = 8;  // width of the data field

  // ------------------------------
  // received character record
  // ------------------------------
  typedef struct packed {
    logic [DATA_W-1:0] data;  // msb reads 0 for 7-bit frames
    logic              parity_err;
    logic              framing_err;
  } rx_char_t;

  // ------------------------------
  // bit timing
  // ------------------------------

  // baud ticks per serial bit
  localparam int TICKS_PER_BIT = 16;

  // low ticks that put us at the middle of the start bit
  localparam int START_MID_TICKS = 8;

endpackage

`default_nettype wire
